// File: mhq_pkg.sv
// Shared line geometry, state and opcode enums and channel structs, imported by every MHQ module
package mhq_pkg;

    // Line geometry is fixed here because every channel struct carries a full line
    localparam int MHQ_ADDR_WIDTH   = 32;
    localparam int MHQ_LINE_SIZE    = 32;
    localparam int MHQ_LINE_WIDTH   = MHQ_LINE_SIZE * 8;
    localparam int MHQ_OFFSET_WIDTH = $clog2(MHQ_LINE_SIZE);

    // A line address drops the byte offset bits
    typedef logic [MHQ_ADDR_WIDTH-MHQ_OFFSET_WIDTH-1:0] mhq_line_addr_t;

    // INVALID means empty, VALID means waiting on the CCU, COMPLETE means ready to fill
    typedef enum logic [1:0] {
        INVALID  = 2'b00,
        VALID    = 2'b01,
        COMPLETE = 2'b10
    } mhq_state_e;

    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } mhq_op_e;

    // Miss request from the LSU, the byte select only matters for stores
    typedef struct packed {
        mhq_op_e                    op;
        mhq_line_addr_t             line_addr;
        logic [MHQ_LINE_WIDTH-1:0]  wdata;
        logic [MHQ_LINE_SIZE-1:0]   byte_sel;
    } mhq_req_t;

    typedef struct packed {
        mhq_line_addr_t             line_addr;
    } mhq_ccu_req_t;

    typedef struct packed {
        mhq_line_addr_t             line_addr;
        logic [MHQ_LINE_WIDTH-1:0]  data;
    } mhq_ccu_rsp_t;

    // What each entry exports to the control and selection blocks
    typedef struct packed {
        logic                       valid;
        logic                       complete;
        logic                       dirty;
        mhq_line_addr_t             line_addr;
        logic [MHQ_LINE_WIDTH-1:0]  data;
    } mhq_entry_t;

    typedef struct packed {
        mhq_line_addr_t             line_addr;
        logic [MHQ_LINE_WIDTH-1:0]  data;
        logic                       dirty;
    } mhq_fill_t;

endpackage

// File: mhq_entry.sv
// One MHQ entry holding a missing line, merging store bytes with CCU data, instantiated per slot by mhq_top
`timescale 1ns/1ps

module mhq_entry
    import mhq_pkg::*;
(
    input  logic           clk,
    input  logic           i_rst,

    // Allocate or merge a request into this entry
    input  logic           i_update_en,
    input  logic           i_alloc,
    input  mhq_req_t       i_req,

    // Line data coming back from the CCU
    input  logic           i_ccu_rsp_valid,
    input  mhq_ccu_rsp_t   i_ccu_rsp,

    // The fill for this entry has left for the LSU
    input  logic           i_fill_launched,

    input  mhq_line_addr_t i_lookup_addr,
    output logic           o_lookup_hit,
    output mhq_entry_t     o_entry
);

    mhq_state_e                state_r;
    mhq_state_e                state_next;
    logic                      dirty_r;
    mhq_line_addr_t            addr_r;
    logic [MHQ_LINE_WIDTH-1:0] data_r;
    logic [MHQ_LINE_SIZE-1:0]  byte_updated_r;

    logic                      entry_valid;
    logic                      allocating;
    logic                      is_store;
    logic                      rsp_match;
    logic                      ccu_done;
    logic [MHQ_LINE_WIDTH-1:0] data_next;
    logic [MHQ_LINE_SIZE-1:0]  byte_updated_next;

    assign entry_valid = (state_r != INVALID);
    assign allocating  = i_update_en & i_alloc;
    assign is_store    = (i_req.op == OP_STORE);

    // The response belongs to whichever live entry holds its line
    assign rsp_match = i_ccu_rsp_valid & entry_valid & (i_ccu_rsp.line_addr == addr_r);
    assign ccu_done  = rsp_match & (state_r == VALID);

    always_comb begin
        state_next = state_r;
        case (state_r)
            INVALID:  if (allocating) state_next = VALID;
            VALID:    if (ccu_done) state_next = COMPLETE;
            COMPLETE: if (i_fill_launched) state_next = INVALID;
            default:  state_next = INVALID;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state_r <= INVALID;
        end else begin
            state_r <= state_next;
        end
    end

    // The address is captured only when the entry is claimed
    always_ff @(posedge clk) begin
        if (allocating) begin
            addr_r <= i_req.line_addr;
        end
    end

    // A fresh allocation starts clean unless it is itself a store, a merge can only add dirt
    always_ff @(posedge clk) begin
        if (i_update_en) begin
            dirty_r <= is_store | (~allocating & dirty_r);
        end
    end

    // Store bytes land first and get marked, then CCU data fills whatever is still unmarked
    always_comb begin
        logic store_byte;
        data_next         = data_r;
        byte_updated_next = allocating ? '0 : byte_updated_r;
        for (int i = 0; i < MHQ_LINE_SIZE; i++) begin
            store_byte = i_update_en & is_store & i_req.byte_sel[i];
            if (store_byte) begin
                data_next[i*8 +: 8] = i_req.wdata[i*8 +: 8];
            end
            byte_updated_next[i] = byte_updated_next[i] | store_byte;
            // A store in the same cycle as the response still wins its bytes
            if (ccu_done && !byte_updated_next[i]) begin
                data_next[i*8 +: 8] = i_ccu_rsp.data[i*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        data_r         <= data_next;
        byte_updated_r <= byte_updated_next;
    end

    assign o_lookup_hit = entry_valid & (addr_r == i_lookup_addr);

    assign o_entry.valid     = entry_valid;
    assign o_entry.complete  = (state_r == COMPLETE);
    assign o_entry.dirty     = dirty_r;
    assign o_entry.line_addr = addr_r;
    assign o_entry.data      = data_r;

    // The CCU answers each request once, so a line that already completed must not see a second response
    a_rsp_only_when_valid: assert property (
        @(posedge clk) disable iff (i_rst)
        rsp_match |-> (state_r == VALID)
    ) else $error("MHQ entry got a CCU response for line %h outside VALID", addr_r);

endmodule

// File: mhq_ctrl.sv
// Request steering for the MHQ, choosing merge or allocate and returning LSU credits, used by mhq_top
`timescale 1ns/1ps

module mhq_ctrl
    import mhq_pkg::*;
#(
    parameter int MHQ_DEPTH = 4
)(
    input  logic                 clk,
    input  logic                 i_rst,

    // Miss request from the LSU
    input  logic                 i_req_valid,
    input  mhq_req_t             i_req,

    // Lookup results and entry state
    input  logic [MHQ_DEPTH-1:0] i_hits,
    input  mhq_entry_t           i_entries [MHQ_DEPTH],
    input  logic [MHQ_DEPTH-1:0] i_fill_launched,

    // Update steering towards the entries
    output mhq_line_addr_t       o_lookup_addr,
    output logic [MHQ_DEPTH-1:0] o_update_en,
    output logic                 o_alloc,
    output mhq_req_t             o_req,

    output logic                 o_req_credit
);

    // Up to two credit events can land in one cycle, so the pending count needs headroom
    localparam int PEND_WIDTH = $clog2(MHQ_DEPTH + 2) + 1;

    logic [MHQ_DEPTH-1:0]  valid_vec;
    logic [MHQ_DEPTH-1:0]  free_vec;
    logic [MHQ_DEPTH-1:0]  free_pick;
    logic                  hit_any;
    logic                  merging;
    logic                  freeing;
    logic [PEND_WIDTH-1:0] pend_r;
    logic [PEND_WIDTH-1:0] pend_total;

    always_comb begin
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            valid_vec[i] = i_entries[i].valid;
        end
    end

    assign free_vec = ~valid_vec;

    // Isolate the lowest free slot with the two's complement trick
    assign free_pick = free_vec & (~free_vec + MHQ_DEPTH'(1));

    assign hit_any = |i_hits;

    // Every entry compares against the incoming line address
    assign o_lookup_addr = i_req.line_addr;
    assign o_req         = i_req;

    // A hit always wins over allocation so a line never owns two entries
    assign o_update_en = i_req_valid ? (hit_any ? i_hits : free_pick) : '0;
    assign o_alloc     = i_req_valid & ~hit_any;

    // Merged requests give their credit back at once, allocations hold it until the fill leaves
    assign merging = i_req_valid & hit_any;
    assign freeing = |i_fill_launched;

    assign pend_total = pend_r + PEND_WIDTH'(merging) + PEND_WIDTH'(freeing);

    // Only one credit pulse per cycle, anything extra waits in the pending count
    always_ff @(posedge clk) begin
        if (i_rst) begin
            pend_r       <= '0;
            o_req_credit <= 1'b0;
        end else begin
            o_req_credit <= (pend_total != '0);
            pend_r       <= (pend_total != '0) ? pend_total - PEND_WIDTH'(1) : '0;
        end
    end

    // The LSU credit count bounds occupancy, so a miss with nowhere to go means a credit leak
    a_no_overrun: assert property (
        @(posedge clk) disable iff (i_rst)
        (i_req_valid && !hit_any) |-> (free_vec != '0)
    ) else $error("MHQ request with no hit arrived while all entries are occupied");

    // Entries for one line are unique, so a lookup may hit at most once
    a_single_hit: assert property (
        @(posedge clk) disable iff (i_rst)
        i_req_valid |-> $onehot0(i_hits)
    ) else $error("MHQ lookup hit more than one entry: %b", i_hits);

endmodule

// File: mhq_ccu_issue.sv
// CCU request issue for the MHQ, sending one line request per entry against CCU credits, used by mhq_top
`timescale 1ns/1ps

module mhq_ccu_issue
    import mhq_pkg::*;
#(
    parameter int MHQ_DEPTH   = 4,
    parameter int CCU_CREDITS = 2
)(
    input  logic                 clk,
    input  logic                 i_rst,

    input  mhq_entry_t           i_entries [MHQ_DEPTH],
    input  logic [MHQ_DEPTH-1:0] i_alloc_en,

    // Credit return and request channel to the CCU
    input  logic                 i_ccu_credit,
    output logic                 o_ccu_req_valid,
    output mhq_ccu_req_t         o_ccu_req
);

    // One spare bit so that a stray credit shows up as an overflow instead of wrapping
    localparam int CNT_WIDTH = $clog2(CCU_CREDITS + 1) + 1;

    logic [MHQ_DEPTH-1:0] requested_r;
    logic [MHQ_DEPTH-1:0] cand_vec;
    logic [MHQ_DEPTH-1:0] pick_vec;
    logic [CNT_WIDTH-1:0] credit_cnt_r;
    logic                 issue;
    mhq_line_addr_t       pick_addr;

    // Waiting entries that have not been sent yet, a completed entry was sent long ago
    always_comb begin
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            cand_vec[i] = i_entries[i].valid & ~i_entries[i].complete & ~requested_r[i];
        end
    end

    assign pick_vec = cand_vec & (~cand_vec + MHQ_DEPTH'(1));
    assign issue    = (cand_vec != '0) & (credit_cnt_r != '0);

    // The pick is one-hot, so an OR over the masked addresses is the mux
    always_comb begin
        pick_addr = '0;
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            pick_addr = pick_addr | (i_entries[i].line_addr & {$bits(mhq_line_addr_t){pick_vec[i]}});
        end
    end

    // Allocation clears the bit so a reused slot gets a fresh request
    always_ff @(posedge clk) begin
        if (i_rst) begin
            requested_r <= '0;
        end else begin
            requested_r <= (requested_r & ~i_alloc_en) | (issue ? pick_vec : '0);
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            credit_cnt_r    <= CNT_WIDTH'(CCU_CREDITS);
            o_ccu_req_valid <= 1'b0;
        end else begin
            credit_cnt_r    <= credit_cnt_r - CNT_WIDTH'(issue) + CNT_WIDTH'(i_ccu_credit);
            o_ccu_req_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            o_ccu_req.line_addr <= pick_addr;
        end
    end

    // The CCU may only hand back credits that the MHQ actually spent
    a_credit_bound: assert property (
        @(posedge clk) disable iff (i_rst)
        credit_cnt_r <= CNT_WIDTH'(CCU_CREDITS)
    ) else $error("MHQ CCU credit count %0d exceeds %0d", credit_cnt_r, CCU_CREDITS);

endmodule

// File: mhq_fill_sel.sv
// Fill selection for the MHQ, sending complete lines to the LSU against fill credits, used by mhq_top
`timescale 1ns/1ps

module mhq_fill_sel
    import mhq_pkg::*;
#(
    parameter int MHQ_DEPTH    = 4,
    parameter int FILL_CREDITS = 1
)(
    input  logic                 clk,
    input  logic                 i_rst,

    input  mhq_entry_t           i_entries [MHQ_DEPTH],
    input  logic [MHQ_DEPTH-1:0] i_update_en,

    // Fill channel to the LSU
    input  logic                 i_fill_credit,
    output logic                 o_fill_valid,
    output mhq_fill_t            o_fill,

    // Frees the chosen entry on the same edge that registers the fill
    output logic [MHQ_DEPTH-1:0] o_fill_launched
);

    localparam int CNT_WIDTH = $clog2(FILL_CREDITS + 1) + 1;

    logic [MHQ_DEPTH-1:0] cand_vec;
    logic [MHQ_DEPTH-1:0] pick_vec;
    logic [CNT_WIDTH-1:0] credit_cnt_r;
    logic                 launch;
    mhq_fill_t            pick_fill;

    // An entry taking a store this cycle would lose those bytes if it left now
    always_comb begin
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            cand_vec[i] = i_entries[i].complete & ~i_update_en[i];
        end
    end

    assign pick_vec = cand_vec & (~cand_vec + MHQ_DEPTH'(1));
    assign launch   = (cand_vec != '0) & (credit_cnt_r != '0);

    assign o_fill_launched = launch ? pick_vec : '0;

    always_comb begin
        pick_fill = '0;
        for (int i = 0; i < MHQ_DEPTH; i++) begin
            if (pick_vec[i]) begin
                pick_fill.line_addr = i_entries[i].line_addr;
                pick_fill.data      = i_entries[i].data;
                pick_fill.dirty     = i_entries[i].dirty;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            credit_cnt_r <= CNT_WIDTH'(FILL_CREDITS);
            o_fill_valid <= 1'b0;
        end else begin
            credit_cnt_r <= credit_cnt_r - CNT_WIDTH'(launch) + CNT_WIDTH'(i_fill_credit);
            o_fill_valid <= launch;
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            o_fill <= pick_fill;
        end
    end

    // A fill needs a held credit and the LSU returns only spent ones, so the count stays in range
    a_fill_credit_bound: assert property (
        @(posedge clk) disable iff (i_rst)
        credit_cnt_r <= CNT_WIDTH'(FILL_CREDITS)
    ) else $error("MHQ fill credit count %0d exceeds %0d", credit_cnt_r, FILL_CREDITS);

endmodule

// File: mhq_top.sv
// Top level of the miss handling queue, connecting the LSU, CCU and fill channels, instantiated by the testbench
`timescale 1ns/1ps

module mhq_top
    import mhq_pkg::*;
#(
    parameter int MHQ_DEPTH    = 4,
    parameter int CCU_CREDITS  = 2,
    parameter int FILL_CREDITS = 1
)(
    input  logic         clk,
    input  logic         i_rst,

    // Miss requests from the LSU
    input  logic         i_req_valid,
    input  mhq_req_t     i_req,
    output logic         o_req_credit,

    // Line requests and responses with the CCU
    output logic         o_ccu_req_valid,
    output mhq_ccu_req_t o_ccu_req,
    input  logic         i_ccu_credit,
    input  logic         i_ccu_rsp_valid,
    input  mhq_ccu_rsp_t i_ccu_rsp,

    // Completed lines towards the LSU
    output logic         o_fill_valid,
    output mhq_fill_t    o_fill,
    input  logic         i_fill_credit
);

    mhq_line_addr_t       lookup_addr;
    logic [MHQ_DEPTH-1:0] update_en;
    logic [MHQ_DEPTH-1:0] alloc_en;
    logic [MHQ_DEPTH-1:0] hits;
    logic [MHQ_DEPTH-1:0] fill_launched;
    logic                 alloc;
    mhq_req_t             req;
    mhq_entry_t           entries [MHQ_DEPTH];

    // Only the slot being claimed sees an allocate enable
    assign alloc_en = update_en & {MHQ_DEPTH{alloc}};

    mhq_ctrl #(
        .MHQ_DEPTH(MHQ_DEPTH)
    ) ctrl_i (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_req_valid    (i_req_valid),
        .i_req          (i_req),
        .i_hits         (hits),
        .i_entries      (entries),
        .i_fill_launched(fill_launched),
        .o_lookup_addr  (lookup_addr),
        .o_update_en    (update_en),
        .o_alloc        (alloc),
        .o_req          (req),
        .o_req_credit   (o_req_credit)
    );

    // The CCU response is broadcast and each entry claims it by address
    for (genvar i = 0; i < MHQ_DEPTH; i++) begin : gen_entry
        mhq_entry entry_i (
            .clk            (clk),
            .i_rst          (i_rst),
            .i_update_en    (update_en[i]),
            .i_alloc        (alloc),
            .i_req          (req),
            .i_ccu_rsp_valid(i_ccu_rsp_valid),
            .i_ccu_rsp      (i_ccu_rsp),
            .i_fill_launched(fill_launched[i]),
            .i_lookup_addr  (lookup_addr),
            .o_lookup_hit   (hits[i]),
            .o_entry        (entries[i])
        );
    end

    mhq_ccu_issue #(
        .MHQ_DEPTH  (MHQ_DEPTH),
        .CCU_CREDITS(CCU_CREDITS)
    ) ccu_issue_i (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_entries      (entries),
        .i_alloc_en     (alloc_en),
        .i_ccu_credit   (i_ccu_credit),
        .o_ccu_req_valid(o_ccu_req_valid),
        .o_ccu_req      (o_ccu_req)
    );

    mhq_fill_sel #(
        .MHQ_DEPTH   (MHQ_DEPTH),
        .FILL_CREDITS(FILL_CREDITS)
    ) fill_sel_i (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_entries      (entries),
        .i_update_en    (update_en),
        .i_fill_credit  (i_fill_credit),
        .o_fill_valid   (o_fill_valid),
        .o_fill         (o_fill),
        .o_fill_launched(fill_launched)
    );

endmodule

// File: mhq_tb.sv
// Directed testbench for mhq_top with CCU and LSU models and a reference line model, run via flist.f
`timescale 1ns/1ps

module mhq_tb
    import mhq_pkg::*;
();

    localparam int MHQ_DEPTH    = 4;
    localparam int CCU_CREDITS  = 2;
    localparam int FILL_CREDITS = 1;
    localparam int CLK_PERIOD   = 4;
    localparam int RAND_ROUNDS  = 20;
    // Rough cycle budget per test where the random rounds dominate
    localparam int TEST_CYCLES  = 30 + 30 + 40 + 80 + 80 + RAND_ROUNDS * 50;
    localparam int WATCHDOG_NS  = TEST_CYCLES * CLK_PERIOD * 3;

    logic         clk;
    logic         i_rst;
    logic         i_req_valid;
    mhq_req_t     i_req;
    logic         o_req_credit;
    logic         o_ccu_req_valid;
    mhq_ccu_req_t o_ccu_req;
    logic         i_ccu_credit;
    logic         i_ccu_rsp_valid;
    mhq_ccu_rsp_t i_ccu_rsp;
    logic         o_fill_valid;
    mhq_fill_t    o_fill;
    logic         i_fill_credit;

    // Observed traffic, filled by the monitor and drained by the tests
    mhq_line_addr_t ccu_req_q [$];
    mhq_fill_t      fill_q [$];
    int             ccu_req_count;
    int             fill_count;
    int             lsu_credits;
    int             fill_owed;
    logic           fill_credit_auto;
    int             seed;

    // Lines with a miss in flight, and the lines still open for stores in a random round
    mhq_line_addr_t pend_q [$];
    mhq_line_addr_t open_q [$];

    // Store bytes written so far per outstanding line while unmarked bytes come from memory
    logic [MHQ_LINE_WIDTH-1:0] exp_store [mhq_line_addr_t];
    logic [MHQ_LINE_SIZE-1:0]  exp_mask [mhq_line_addr_t];
    logic                      exp_dirty [mhq_line_addr_t];

    mhq_top #(
        .MHQ_DEPTH   (MHQ_DEPTH),
        .CCU_CREDITS (CCU_CREDITS),
        .FILL_CREDITS(FILL_CREDITS)
    ) dut_i (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_req_valid    (i_req_valid),
        .i_req          (i_req),
        .o_req_credit   (o_req_credit),
        .o_ccu_req_valid(o_ccu_req_valid),
        .o_ccu_req      (o_ccu_req),
        .i_ccu_credit   (i_ccu_credit),
        .i_ccu_rsp_valid(i_ccu_rsp_valid),
        .i_ccu_rsp      (i_ccu_rsp),
        .o_fill_valid   (o_fill_valid),
        .o_fill         (o_fill),
        .i_fill_credit  (i_fill_credit)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    initial begin
        #(WATCHDOG_NS);
        fail_run("Watchdog timeout, the DUT stopped answering within the test budget");
    end

    // Outputs are registered on the rising edge, so the falling edge sees them settled
    always @(negedge clk) begin
        if (!i_rst) begin
            if (o_req_credit) begin
                lsu_credits = lsu_credits + 1;
            end
            if (o_ccu_req_valid) begin
                ccu_req_q.push_back(o_ccu_req.line_addr);
                ccu_req_count = ccu_req_count + 1;
            end
            if (o_fill_valid) begin
                fill_q.push_back(o_fill);
                fill_count = fill_count + 1;
                fill_owed  = fill_owed + 1;
            end
        end
    end

    // LSU side hands fill credits back one per cycle unless a test holds them
    always @(posedge clk) begin
        #1;
        if (fill_credit_auto && fill_owed > 0) begin
            i_fill_credit = 1'b1;
            fill_owed     = fill_owed - 1;
        end else begin
            i_fill_credit = 1'b0;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_val(string test, string what, logic [255:0] exp, logic [255:0] act);
        assert (act === exp) else begin
            fail_run($sformatf("Error: %s %s expected %0h actual %0h", test, what, exp, act));
        end
    endtask

    // Memory contents are a hash of the whole line address
    function automatic logic [MHQ_LINE_WIDTH-1:0] mem_line(mhq_line_addr_t addr);
        logic [MHQ_LINE_WIDTH-1:0] line;
        logic [31:0]               base;
        base = {5'b0, addr} * 32'h9E37_79B1;
        for (int w = 0; w < MHQ_LINE_WIDTH / 32; w++) begin
            line[w*32 +: 32] = (base + 32'(w) * 32'h0101_0101) ^ {5'b0, addr};
        end
        return line;
    endfunction

    function automatic logic [MHQ_LINE_WIDTH-1:0] expected_line(mhq_line_addr_t addr);
        logic [MHQ_LINE_WIDTH-1:0] mem;
        logic [MHQ_LINE_WIDTH-1:0] line;
        mem = mem_line(addr);
        for (int i = 0; i < MHQ_LINE_SIZE; i++) begin
            line[i*8 +: 8] = exp_mask[addr][i] ? exp_store[addr][i*8 +: 8] : mem[i*8 +: 8];
        end
        return line;
    endfunction

    function automatic void model_apply(mhq_op_e op, mhq_line_addr_t addr,
                                        logic [MHQ_LINE_WIDTH-1:0] wdata,
                                        logic [MHQ_LINE_SIZE-1:0] sel);
        logic [MHQ_LINE_WIDTH-1:0] data;
        logic [MHQ_LINE_SIZE-1:0]  mask;
        if (!exp_dirty.exists(addr)) begin
            exp_dirty[addr] = 1'b0;
            exp_mask[addr]  = '0;
            exp_store[addr] = '0;
        end
        data = exp_store[addr];
        mask = exp_mask[addr];
        if (op == OP_STORE) begin
            exp_dirty[addr] = 1'b1;
            for (int i = 0; i < MHQ_LINE_SIZE; i++) begin
                if (sel[i]) begin
                    data[i*8 +: 8] = wdata[i*8 +: 8];
                    mask[i]        = 1'b1;
                end
            end
        end
        exp_store[addr] = data;
        exp_mask[addr]  = mask;
    endfunction

    // Spends one LSU credit, waiting for one if none is held
    task automatic send_req(mhq_op_e op, mhq_line_addr_t addr,
                            logic [MHQ_LINE_WIDTH-1:0] wdata, logic [MHQ_LINE_SIZE-1:0] sel);
        while (lsu_credits == 0) begin
            next_cycle();
        end
        i_req_valid = 1'b1;
        i_req       = '{op: op, line_addr: addr, wdata: wdata, byte_sel: sel};
        lsu_credits = lsu_credits - 1;
        model_apply(op, addr, wdata, sel);
        next_cycle();
        i_req_valid = 1'b0;
    endtask

    task automatic send_random_store(mhq_line_addr_t addr);
        logic [MHQ_LINE_WIDTH-1:0] wdata;
        logic [MHQ_LINE_SIZE-1:0]  sel;
        for (int w = 0; w < MHQ_LINE_WIDTH / 32; w++) begin
            wdata[w*32 +: 32] = $random(seed);
        end
        sel = $random(seed);
        send_req(OP_STORE, addr, wdata, sel);
    endtask

    task automatic ccu_respond(mhq_line_addr_t addr, logic give_credit);
        i_ccu_rsp_valid = 1'b1;
        i_ccu_rsp       = '{line_addr: addr, data: mem_line(addr)};
        i_ccu_credit    = give_credit;
        next_cycle();
        i_ccu_rsp_valid = 1'b0;
        i_ccu_credit    = 1'b0;
    endtask

    task automatic return_ccu_credit();
        i_ccu_credit = 1'b1;
        next_cycle();
        i_ccu_credit = 1'b0;
    endtask

    task automatic wait_ccu_req(string test, mhq_line_addr_t exp_addr);
        mhq_line_addr_t addr;
        while (ccu_req_q.size() == 0) begin
            next_cycle();
        end
        addr = ccu_req_q.pop_front();
        check_val(test, "CCU request line", 256'(exp_addr), 256'(addr));
    endtask

    // A fill for a line without an outstanding miss is a duplicate or a stray
    task automatic check_next_fill(string test);
        mhq_fill_t f;
        while (fill_q.size() == 0) begin
            next_cycle();
        end
        f = fill_q.pop_front();
        assert (exp_dirty.exists(f.line_addr)) else begin
            fail_run($sformatf("%s got a fill for line %h that has no miss in flight",
                               test, f.line_addr));
        end
        check_val(test, "fill data", expected_line(f.line_addr), f.data);
        check_val(test, "fill dirty", 256'(exp_dirty[f.line_addr]), 256'(f.dirty));
        exp_dirty.delete(f.line_addr);
        exp_mask.delete(f.line_addr);
        exp_store.delete(f.line_addr);
    endtask

    task automatic wait_credits_home(string test);
        while (lsu_credits < MHQ_DEPTH) begin
            next_cycle();
        end
        repeat (4) next_cycle();
        check_val(test, "LSU credits", 256'(MHQ_DEPTH), 256'(lsu_credits));
        check_val(test, "extra fills", 256'(0), 256'(fill_q.size()));
        check_val(test, "extra CCU requests", 256'(0), 256'(ccu_req_q.size()));
    endtask

    task automatic respond_to_random_pending();
        int             idx;
        int             found;
        mhq_line_addr_t addr;
        while (ccu_req_q.size() > 0) begin
            pend_q.push_back(ccu_req_q.pop_front());
        end
        if (pend_q.size() == 0) begin
            next_cycle();
        end else begin
            idx   = int'($unsigned($random(seed)) % pend_q.size());
            addr  = pend_q[idx];
            found = 0;
            pend_q.delete(idx);
            for (int i = open_q.size() - 1; i >= 0; i--) begin
                if (open_q[i] == addr) begin
                    open_q.delete(i);
                    found = 1;
                end
            end
            check_val("random_stores", "CCU request for an open line", 256'(1), 256'(found));
            ccu_respond(addr, 1'b1);
        end
    endtask

    task automatic test_load_miss();
        mhq_line_addr_t a;
        a = 27'h000_0100;
        send_req(OP_LOAD, a, '0, '0);
        wait_ccu_req("load_miss", a);
        ccu_respond(a, 1'b1);
        check_next_fill("load_miss");
        wait_credits_home("load_miss");
    endtask

    task automatic test_store_miss();
        logic [MHQ_LINE_WIDTH-1:0] wdata;
        mhq_line_addr_t            a;
        a = 27'h123_4560;
        for (int w = 0; w < MHQ_LINE_WIDTH / 32; w++) begin
            wdata[w*32 +: 32] = $random(seed);
        end
        send_req(OP_STORE, a, wdata, 32'h0F0F_00FF);
        wait_ccu_req("store_miss", a);
        ccu_respond(a, 1'b1);
        check_next_fill("store_miss");
        wait_credits_home("store_miss");
    endtask

    // Two later requests to the same line must fold into the first entry
    task automatic test_merge();
        mhq_line_addr_t a;
        int             c0;
        a  = 27'h0AB_CDE0;
        c0 = ccu_req_count;
        send_req(OP_LOAD, a, '0, '0);
        send_req(OP_LOAD, a, '0, '0);
        send_random_store(a);
        wait_ccu_req("merge", a);
        repeat (3) next_cycle();
        check_val("merge", "LSU credits before fill", 256'(MHQ_DEPTH - 1), 256'(lsu_credits));
        check_val("merge", "CCU request count", 256'(1), 256'(ccu_req_count - c0));
        ccu_respond(a, 1'b1);
        check_next_fill("merge");
        wait_credits_home("merge");
    endtask

    task automatic test_ccu_backpressure();
        mhq_line_addr_t a [3];
        int             c0;
        a  = '{27'h000_0200, 27'h000_0201, 27'h000_0202};
        c0 = ccu_req_count;
        for (int i = 0; i < 3; i++) begin
            send_req(OP_LOAD, a[i], '0, '0);
        end
        repeat (10) next_cycle();
        check_val("ccu_backpressure", "CCU requests", 256'(CCU_CREDITS), 256'(ccu_req_count - c0));
        wait_ccu_req("ccu_backpressure", a[0]);
        wait_ccu_req("ccu_backpressure", a[1]);
        // Answer both but keep the credits, so the third miss stays parked
        ccu_respond(a[0], 1'b0);
        ccu_respond(a[1], 1'b0);
        check_next_fill("ccu_backpressure");
        check_next_fill("ccu_backpressure");
        repeat (5) next_cycle();
        check_val("ccu_backpressure", "CCU requests", 256'(CCU_CREDITS), 256'(ccu_req_count - c0));
        return_ccu_credit();
        return_ccu_credit();
        wait_ccu_req("ccu_backpressure", a[2]);
        ccu_respond(a[2], 1'b1);
        check_next_fill("ccu_backpressure");
        wait_credits_home("ccu_backpressure");
    endtask

    task automatic test_fill_backpressure();
        mhq_line_addr_t a [3];
        int             f0;
        a  = '{27'h000_0300, 27'h7FF_0300, 27'h000_0301};
        f0 = fill_count;
        fill_credit_auto = 1'b0;
        send_req(OP_LOAD, a[0], '0, '0);
        send_random_store(a[1]);
        send_req(OP_LOAD, a[2], '0, '0);
        for (int i = 0; i < 3; i++) begin
            wait_ccu_req("fill_backpressure", a[i]);
            ccu_respond(a[i], 1'b1);
        end
        repeat (10) next_cycle();
        check_val("fill_backpressure", "fills", 256'(FILL_CREDITS), 256'(fill_count - f0));
        fill_credit_auto = 1'b1;
        repeat (3) check_next_fill("fill_backpressure");
        wait_credits_home("fill_backpressure");
    endtask

    // Stores keep landing on lines that are still waiting while responses come back shuffled
    task automatic test_random_stores();
        mhq_line_addr_t lines [3];
        int             idx;
        lines = '{27'h000_0040, 27'h400_0040, 27'h000_0041};
        for (int r = 0; r < RAND_ROUNDS; r++) begin
            open_q.delete();
            pend_q.delete();
            for (int l = 0; l < 3; l++) begin
                open_q.push_back(lines[l]);
                send_random_store(lines[l]);
            end
            for (int k = 0; k < 8; k++) begin
                if ((($random(seed) & 1) != 0) && open_q.size() > 0) begin
                    idx = int'($unsigned($random(seed)) % open_q.size());
                    send_random_store(open_q[idx]);
                end else begin
                    respond_to_random_pending();
                end
            end
            while (open_q.size() > 0) begin
                respond_to_random_pending();
            end
            repeat (3) check_next_fill("random_stores");
            wait_credits_home("random_stores");
        end
    endtask

    initial begin
        seed             = 46;
        i_rst            = 1'b1;
        i_req_valid      = 1'b0;
        i_req            = '0;
        i_ccu_credit     = 1'b0;
        i_ccu_rsp_valid  = 1'b0;
        i_ccu_rsp        = '0;
        i_fill_credit    = 1'b0;
        fill_credit_auto = 1'b1;
        fill_owed        = 0;
        lsu_credits      = MHQ_DEPTH;
        ccu_req_count    = 0;
        fill_count       = 0;
        repeat (3) @(posedge clk);
        #1;
        i_rst = 1'b0;
        check_val("reset", "o_req_credit", 256'(0), 256'(o_req_credit));
        check_val("reset", "o_ccu_req_valid", 256'(0), 256'(o_ccu_req_valid));
        check_val("reset", "o_fill_valid", 256'(0), 256'(o_fill_valid));
        test_load_miss();
        test_store_miss();
        test_merge();
        test_ccu_backpressure();
        test_fill_backpressure();
        test_random_stores();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: flist.f
mhq_pkg.sv
mhq_entry.sv
mhq_ctrl.sv
mhq_ccu_issue.sv
mhq_fill_sel.sv
mhq_top.sv
mhq_tb.sv

// File: Makefile
# Verilator build and run for the MHQ testbench

VERILATOR ?= verilator
TOP       ?= mhq_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -f $(FLIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
